// File: hdl/piano_pkg.sv
// piano tone path definitions
package piano_pkg;

    typedef logic [7:0] sample_t;   // note amplitude, shaped voice or mix

    // same layout as bits 25..0 of an spi frame
    typedef struct packed {
        logic [1:0] note_count;
        sample_t    note3;
        sample_t    note2;
        sample_t    note1;
    } chord_t;

    // one {active, done} pair per voice
    typedef struct packed {
        logic voice1_active;
        logic voice1_done;
        logic voice2_active;
        logic voice2_done;
        logic voice3_active;
        logic voice3_done;
    } voice_status_t;

    localparam int FRAME_BITS = 32;
    localparam logic [FRAME_BITS-1:0] SYNC_WORD = 32'h0000_ffff;   // arms the receiver

    localparam int ENV_STEPS  = 16;
    localparam int GAIN_SHIFT = 7;   // gains are in 128ths

    // attack up to the peak at step 4, then a long decay
    localparam logic [7:0] ENV_GAIN [ENV_STEPS] = '{
        8'd24,  8'd48,  8'd80,  8'd112,
        8'd128, 8'd120, 8'd112, 8'd104,
        8'd96,  8'd88,  8'd72,  8'd56,
        8'd40,  8'd28,  8'd16,  8'd8
    };

    localparam int LEAD_BITS = 4;   // zero bits ahead of the sample in a dac frame

endpackage

// File: hdl/spi_frame_rx.sv
// spi chord receiver
module spi_frame_rx (
    input  logic              clk,
    input  logic              reset,
    input  logic              sck,
    input  logic              sdi,
    output piano_pkg::chord_t chord
);
    import piano_pkg::*;

    localparam int cnt_w = $clog2(FRAME_BITS);

    logic [1:0]            sck_sync;
    logic [1:0]            sdi_sync;
    logic                  sck_last;
    logic                  sck_rise;
    logic [FRAME_BITS-1:0] shift_reg;
    logic                  synced;
    logic [cnt_w-1:0]      bit_cnt;
    logic                  frame_end;

    assign sck_rise = sck_sync[1] & ~sck_last;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sck_sync <= '0;
            sdi_sync <= '0;
            sck_last <= 1'b0;
        end
        else
        begin
            sck_sync <= {sck_sync[0], sck};
            sdi_sync <= {sdi_sync[0], sdi};   // same delay as sck
            sck_last <= sck_sync[1];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            shift_reg <= '0;
            synced    <= 1'b0;
            bit_cnt   <= '0;
            frame_end <= 1'b0;
        end
        else
        begin
            frame_end <= 1'b0;
            if (sck_rise)
                shift_reg <= {shift_reg[FRAME_BITS-2:0], sdi_sync[1]};   // msb first
            if (!synced)
            begin
                if (shift_reg == SYNC_WORD)
                    synced <= 1'b1;   // next bit starts a frame
            end
            else if (sck_rise)
            begin
                bit_cnt <= bit_cnt + 1'b1;   // wraps once per frame
                if (bit_cnt == cnt_w'(FRAME_BITS - 1))
                    frame_end <= 1'b1;
            end
        end
    end

    // held chord, stays put between frames
    always_ff @(posedge clk)
    begin
        if (reset)
            chord <= '0;
        else if (frame_end)
            chord <= chord_t'(shift_reg[$bits(chord_t)-1:0]);
    end

endmodule

// File: hdl/note_envelope.sv
// piano note envelope
module note_envelope #(
    parameter int env_step_cycles = 7500000
) (
    input  logic               clk,
    input  logic               reset,
    input  piano_pkg::sample_t note,
    output piano_pkg::sample_t voice,
    output logic               active,
    output logic               done
);
    import piano_pkg::*;

    localparam int cnt_w = $clog2(env_step_cycles + 1);

    logic [cnt_w-1:0]             step_cnt;   // cycles within the current step
    logic [$clog2(ENV_STEPS)-1:0] step_idx;
    logic                         finished;   // whole envelope has run out
    logic [15:0]                  product;

    assign product = note * ENV_GAIN[step_idx];

    always_ff @(posedge clk)
    begin
        if (reset || note == '0)
        begin
            step_cnt <= '0;
            step_idx <= '0;
            finished <= 1'b0;
        end
        else if (!finished)
        begin
            if (step_cnt == cnt_w'(env_step_cycles - 1))
            begin
                step_cnt <= '0;
                if (step_idx == $bits(step_idx)'(ENV_STEPS - 1))
                    finished <= 1'b1;   // hold here until the note goes away
                else
                    step_idx <= step_idx + 1'b1;
            end
            else
                step_cnt <= step_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || note == '0)
        begin
            voice  <= '0;
            active <= 1'b0;
            done   <= 1'b0;
        end
        else if (finished)
        begin
            voice  <= '0;
            active <= 1'b0;
            done   <= 1'b1;
        end
        else
        begin
            voice  <= product[GAIN_SHIFT +: 8];   // note * gain / 128
            active <= 1'b1;
            done   <= 1'b0;
        end
    end

endmodule

// File: hdl/voice_mixer.sv
// three voice mixer
module voice_mixer (
    input  logic               clk,
    input  logic               reset,
    input  piano_pkg::sample_t voice1,
    input  piano_pkg::sample_t voice2,
    input  piano_pkg::sample_t voice3,
    input  logic [1:0]         note_count,
    output piano_pkg::sample_t mixed
);
    import piano_pkg::*;

    function automatic sample_t saturate(input logic [9:0] value);
        return (value > 10'd255) ? 8'd255 : value[7:0];
    endfunction

    logic [9:0] sum;
    logic [9:0] third;
    sample_t    scaled;

    assign sum   = 10'(voice1) + 10'(voice2) + 10'(voice3);
    assign third = (sum >> 2) + (sum >> 4) + (sum >> 6) + (sum >> 8);   // roughly sum / 3

    always_comb
    begin
        case (note_count)
            2'd0:    scaled = '0;
            2'd1:    scaled = saturate(sum);
            2'd2:    scaled = saturate(sum >> 1);
            default: scaled = third[7:0];   // never above 251
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            mixed <= '0;
        else
            mixed <= scaled;
    end

endmodule

// File: hdl/dac_serializer.sv
// serial dac driver
module dac_serializer #(
    parameter int bit_cycles  = 40,
    parameter int load_cycles = 40,
    parameter int ldac_cycles = 40
) (
    input  logic               clk,
    input  logic               reset,
    input  piano_pkg::sample_t sample,
    output logic               dclk,
    output logic               data,
    output logic               load,
    output logic               ldac
);
    import piano_pkg::*;

    localparam int lead_end  = LEAD_BITS * bit_cycles;
    localparam int shift_end = (LEAD_BITS + 8) * bit_cycles;
    localparam int load_end  = shift_end + load_cycles;
    localparam int ldac_end  = load_end + ldac_cycles;
    localparam int frame_len = ldac_end + 1;   // one idle cycle at the end
    localparam int frame_w   = $clog2(frame_len);
    localparam int phase_w   = $clog2(bit_cycles);

    logic [frame_w-1:0] frame_cnt;
    logic [phase_w-1:0] bit_cnt;
    logic               shifting;
    logic               in_data;
    logic               last_phase;
    sample_t            sample_reg;

    assign shifting   = frame_cnt < frame_w'(shift_end);
    assign in_data    = shifting && frame_cnt >= frame_w'(lead_end);
    assign last_phase = bit_cnt == phase_w'(bit_cycles - 1);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            frame_cnt <= '0;
            bit_cnt   <= '0;
            dclk      <= 1'b0;
            data      <= 1'b0;
            load      <= 1'b1;
            ldac      <= 1'b1;
        end
        else
        begin
            if (frame_cnt == frame_w'(frame_len - 1))
                frame_cnt <= '0;
            else
                frame_cnt <= frame_cnt + 1'b1;

            if (!shifting || last_phase)
                bit_cnt <= '0;
            else
                bit_cnt <= bit_cnt + 1'b1;

            dclk <= shifting && bit_cnt < phase_w'(bit_cycles / 2);   // high in first half
            data <= in_data && sample_reg[7];   // lead bits are zero
            load <= !(frame_cnt >= frame_w'(shift_end) && frame_cnt < frame_w'(load_end));
            ldac <= !(frame_cnt >= frame_w'(load_end) && frame_cnt < frame_w'(ldac_end));
        end
    end

    always_ff @(posedge clk)
    begin
        if (frame_cnt == '0)
            sample_reg <= sample;   // one mixed sample per dac frame
        else if (in_data && last_phase)
            sample_reg <= {sample_reg[6:0], 1'b0};
    end

endmodule

// File: hdl/piano_top.sv
// piano tone path top
module piano_top #(
    parameter int bit_cycles      = 40,
    parameter int env_step_cycles = 7500000,
    parameter int load_cycles     = 40,
    parameter int ldac_cycles     = 40
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     sck,
    input  logic                     sdi,
    output piano_pkg::voice_status_t voice_status,
    output logic                     dclk,
    output logic                     data,
    output logic                     load,
    output logic                     ldac
);
    import piano_pkg::*;

    chord_t     chord;
    sample_t    voice1;
    sample_t    voice2;
    sample_t    voice3;
    sample_t    mixed;
    logic [2:0] active;
    logic [2:0] done;

    assign voice_status = {active[0], done[0], active[1], done[1], active[2], done[2]};

    spi_frame_rx i_spi_frame_rx (
        .clk   (clk),
        .reset (reset),
        .sck   (sck),
        .sdi   (sdi),
        .chord (chord)
    );

    note_envelope #(.env_step_cycles(env_step_cycles)) i_note_envelope1 (
        .clk    (clk),
        .reset  (reset),
        .note   (chord.note1),
        .voice  (voice1),
        .active (active[0]),
        .done   (done[0])
    );

    note_envelope #(.env_step_cycles(env_step_cycles)) i_note_envelope2 (
        .clk    (clk),
        .reset  (reset),
        .note   (chord.note2),
        .voice  (voice2),
        .active (active[1]),
        .done   (done[1])
    );

    note_envelope #(.env_step_cycles(env_step_cycles)) i_note_envelope3 (
        .clk    (clk),
        .reset  (reset),
        .note   (chord.note3),
        .voice  (voice3),
        .active (active[2]),
        .done   (done[2])
    );

    voice_mixer i_voice_mixer (
        .clk        (clk),
        .reset      (reset),
        .voice1     (voice1),
        .voice2     (voice2),
        .voice3     (voice3),
        .note_count (chord.note_count),
        .mixed      (mixed)
    );

    dac_serializer #(
        .bit_cycles  (bit_cycles),
        .load_cycles (load_cycles),
        .ldac_cycles (ldac_cycles)
    ) i_dac_serializer (
        .clk    (clk),
        .reset  (reset),
        .sample (mixed),
        .dclk   (dclk),
        .data   (data),
        .load   (load),
        .ldac   (ldac)
    );

endmodule

// File: bench/piano_checker.sv
// dac control pin assertions
module piano_checker (
    input logic clk,
    input logic reset,
    input logic dclk,
    input logic load,
    input logic ldac
);
    int fail_count = 0;   // summed into the testbench result

    load_ldac_apart: assert property (@(posedge clk) disable iff (reset) load || ldac)
    else
    begin
        $error("load and ldac low together");
        fail_count++;
    end

    // no clock pulses while the dac latches
    dclk_quiet: assert property (@(posedge clk) disable iff (reset) (!load || !ldac) |-> !dclk)
    else
    begin
        $error("dclk high during a load or ldac phase");
        fail_count++;
    end

    reset_idle: assert property (@(posedge clk) reset |=> load && ldac)
    else
    begin
        $error("load or ldac low right after reset");
        fail_count++;
    end

endmodule

bind dac_serializer piano_checker i_dac_checker (
    .clk   (clk),
    .reset (reset),
    .dclk  (dclk),
    .load  (load),
    .ldac  (ldac)
);

// File: bench/piano_tb.sv
// piano tone path testbench
module piano_tb #(
    parameter int bit_cycles      = 4,
    parameter int env_step_cycles = 20,
    parameter int load_cycles     = 4,
    parameter int ldac_cycles     = 4
);
    import piano_pkg::*;

    localparam int frame_len      = (LEAD_BITS + 8) * bit_cycles + load_cycles + ldac_cycles + 1;
    localparam int env_lag        = 7;     // last sck rise to mixer output, through rx and envelope
    localparam int rise_offset    = (FRAME_BITS - 1) * 8 + 4;   // frame start to its last sck rise
    localparam int test_note      = 200;
    localparam int timeout_cycles = 20000;   // tests need roughly 5500 cycles

    logic          clk;
    logic          reset;
    logic          sck;
    logic          sdi;
    voice_status_t voice_status;
    logic          dclk;
    logic          data;
    logic          load;
    logic          ldac;

    int cycle = 0;
    int errors;
    int assert_fails;
    int last_rise;        // cycle of the final sck rise of the latest frame
    int last_load_fall;

    piano_top #(
        .bit_cycles      (bit_cycles),
        .env_step_cycles (env_step_cycles),
        .load_cycles     (load_cycles),
        .ldac_cycles     (ldac_cycles)
    ) i_piano_top (
        .clk          (clk),
        .reset        (reset),
        .sck          (sck),
        .sdi          (sdi),
        .voice_status (voice_status),
        .dclk         (dclk),
        .data         (data),
        .load         (load),
        .ldac         (ldac)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles)
        begin
            $display("timeout after %0d cycles, tests did not complete", timeout_cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [FRAME_BITS-1:0] build_frame(input logic [1:0] count,
        input sample_t n1, input sample_t n2, input sample_t n3);
        chord_t ch;
        ch.note_count = count;
        ch.note1      = n1;
        ch.note2      = n2;
        ch.note3      = n3;
        return {{(FRAME_BITS - $bits(chord_t)){1'b0}}, ch};
    endfunction

    // silent before the attack and after the last step
    function automatic int shaped(input int note, input int step);
        if (step < 0 || step >= ENV_STEPS)
            return 0;
        return (note * ENV_GAIN[step]) / (1 << GAIN_SHIFT);
    endfunction

    function automatic int mix_rule(input int count, input int v1, input int v2, input int v3);
        int sum;
        sum = v1 + v2 + v3;
        case (count)
            0:       return 0;
            1:       return (sum > 255) ? 255 : sum;
            2:       return (sum / 2 > 255) ? 255 : sum / 2;
            default: return sum / 4 + sum / 16 + sum / 64 + sum / 256;
        endcase
    endfunction

    task automatic compare_value(input string name, input int expected, input int actual);
        if (expected != actual)
        begin
            errors++;
            $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic send_frame(input logic [FRAME_BITS-1:0] frame);
        for (int i = FRAME_BITS - 1; i >= 0; i--)
        begin
            sdi = frame[i];
            sck = 1'b0;
            repeat (4) @(negedge clk);
            sck = 1'b1;
            last_rise = cycle;
            repeat (4) @(negedge clk);
        end
        sck = 1'b0;
    endtask

    // chained means the previous call just returned at an ldac rise
    task automatic decode_frame(input bit chained, output int value, output int latch);
        logic [11:0] bits;
        logic        dclk_prev;
        int          rises;
        int          falls;
        int          load_fall;
        int          load_len;
        int          ldac_len;
        if (!chained)
        begin
            @(negedge clk);
            while (ldac)
                @(negedge clk);
            while (!ldac)
                @(negedge clk);
        end
        @(negedge clk);
        while (!dclk)
            @(negedge clk);
        latch     = cycle;   // sample register loaded on the edge just before
        bits      = '0;
        rises     = 1;
        falls     = 0;
        dclk_prev = 1'b1;
        while (load)
        begin
            @(negedge clk);
            if (dclk && !dclk_prev)
                rises++;
            if (!dclk && dclk_prev)
            begin
                bits = {bits[10:0], data};
                falls++;
            end
            dclk_prev = dclk;
        end
        load_fall = cycle;
        load_len  = 0;
        ldac_len  = 0;
        while (!load)
        begin
            load_len++;
            @(negedge clk);
        end
        while (!ldac)
        begin
            ldac_len++;
            @(negedge clk);
        end
        compare_value("dclk rises", LEAD_BITS + 8, rises);
        compare_value("dclk falls", LEAD_BITS + 8, falls);
        compare_value("lead bits", 0, bits[11:8]);
        compare_value("load low cycles", load_cycles, load_len);
        compare_value("ldac low cycles", ldac_cycles, ldac_len);
        if (chained)
            compare_value("load fall period", frame_len, load_fall - last_load_fall);
        last_load_fall = load_fall;
        value          = bits[7:0];
    endtask

    task automatic sync_arming();
        voice_status_t exp_status;
        int            value;
        int            latch;
        send_frame(build_frame(2'd1, 8'd150, 8'd0, 8'd0));   // receiver still unarmed
        repeat (10) @(negedge clk);
        compare_value("voice_status", 0, voice_status);
        decode_frame(1'b0, value, latch);
        compare_value("dac sample", 0, value);
        send_frame(SYNC_WORD);
        send_frame(build_frame(2'd1, sample_t'(test_note), 8'd0, 8'd0));
        repeat (10) @(negedge clk);
        exp_status               = '0;
        exp_status.voice1_active = 1'b1;
        compare_value("voice_status", exp_status, voice_status);
    endtask

    task automatic envelope_shape();
        int value;
        int latch;
        int elapsed;
        int step;
        int now_exp;
        int prev_exp;
        bit chained;
        step    = -1;
        chained = 1'b0;
        while (step < ENV_STEPS)
        begin
            decode_frame(chained, value, latch);
            chained  = 1'b1;
            elapsed  = latch - last_rise - env_lag;
            step     = (elapsed < 0) ? -1 : elapsed / env_step_cycles;
            now_exp  = mix_rule(1, shaped(test_note, step), 0, 0);
            prev_exp = mix_rule(1, shaped(test_note, step - 1), 0, 0);
            if (elapsed % env_step_cycles != 0 || value != prev_exp)   // slack only at a boundary
                compare_value("dac sample", now_exp, value);
        end
    endtask

    task automatic envelope_release();
        voice_status_t exp_status;
        int            value;
        int            latch;
        while (cycle < last_rise + env_lag + ENV_STEPS * env_step_cycles)
            @(negedge clk);
        exp_status             = '0;
        exp_status.voice1_done = 1'b1;
        compare_value("voice_status", exp_status, voice_status);
        decode_frame(1'b0, value, latch);
        compare_value("dac sample", 0, value);
        send_frame(build_frame(2'd1, 8'd0, 8'd0, 8'd0));
        repeat (10) @(negedge clk);
        compare_value("voice_status", 0, voice_status);
    endtask

    // times the chord so that one dac latch lands in the middle of the peak step
    task automatic mix_trial(input logic [1:0] count);
        int n1;
        int n2;
        int n3;
        int value;
        int latch;
        int target;
        int step;
        bit chained;
        n1 = $urandom_range(255, 1);
        n2 = $urandom_range(255, 1);
        n3 = $urandom_range(255, 1);
        send_frame(build_frame(count, 8'd0, 8'd0, 8'd0));   // zero notes restart the envelopes
        decode_frame(1'b0, value, latch);
        target = latch;
        while (target - env_lag - 9 * env_step_cycles / 2 - rise_offset <= cycle)
            target += frame_len;
        while (cycle < target - env_lag - 9 * env_step_cycles / 2 - rise_offset)
            @(negedge clk);
        send_frame(build_frame(count, sample_t'(n1), sample_t'(n2), sample_t'(n3)));
        step    = -1;
        chained = 1'b0;
        while (step < 4)
        begin
            decode_frame(chained, value, latch);
            chained = 1'b1;
            step    = (latch - last_rise - env_lag) / env_step_cycles;
        end
        if (step == 4)
            compare_value("mixed dac sample", mix_rule(count, n1, n2, n3), value);
        else
        begin
            errors++;
            $display("mix trial with count %0d latched no sample during the peak step", count);
        end
    endtask

    initial
    begin
        reset  = 1'b1;
        sck    = 1'b0;
        sdi    = 1'b0;
        errors = 0;
        void'($urandom(32'hdd43f5fe));
        repeat (10) @(negedge clk);
        reset = 1'b0;
        sync_arming();
        envelope_shape();
        envelope_release();
        mix_trial(2'd2);
        mix_trial(2'd3);
        mix_trial(2'd3);
        mix_trial(2'd0);
        assert_fails = i_piano_top.i_dac_serializer.i_dac_checker.fail_count;
        $display("check errors %0d, assertion failures %0d", errors, assert_fails);
        if (errors == 0 && assert_fails == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: filelist.f
hdl/piano_pkg.sv
hdl/spi_frame_rx.sv
hdl/note_envelope.sv
hdl/voice_mixer.sv
hdl/dac_serializer.sv
hdl/piano_top.sv
bench/piano_checker.sv
bench/piano_tb.sv
